//--- hw/renkon_consts.svh
`ifndef RENKON_CONSTS_SVH
`define RENKON_CONSTS_SVH

// **********************************************************
// Fixed-point format and image limits
// **********************************************************

`define DWIDTH 16    // Data word width.
`define FRAC 8       // Fractional bits.
`define MAX_WIDTH 32 // Widest image line.

`endif

//--- hw/conv_pkg.sv
`default_nettype none

`include "renkon_consts.svh"

package conv_pkg;

  typedef logic signed [`DWIDTH-1:0] data_t;    // Pixel, weight, bias, feature.
  typedef logic signed [2*`DWIDTH-1:0] prod_t;  // Full-width product.
  typedef logic [$clog2(`MAX_WIDTH+1)-1:0] cnt_t; // Sizes and counters.

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/conv_tree9.sv
`timescale 1ns/10ps
`default_nettype none

`include "renkon_consts.svh"

module conv_tree9 (
  input  logic            clk,
  input  logic            xrst,
  input  conv_pkg::data_t pixel  [9],
  input  conv_pkg::data_t weight [9],
  output conv_pkg::data_t fmap
);
  import conv_pkg::*;

  localparam int TAPS = 9;

  data_t r_pixel  [TAPS];
  data_t r_weight [TAPS];
  prod_t r_pro    [TAPS];
  data_t r_short  [TAPS];
  data_t r_sum;

  data_t lvl0 [4];
  data_t lvl1 [2];
  data_t lvl2;
  data_t lvl3;

  // **********************************************************
  // Operand and product registers
  // **********************************************************

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      for (int i = 0; i < TAPS; i++) begin
        r_pixel[i]  <= '0;
        r_weight[i] <= '0;
        r_pro[i]    <= '0;
      end
    end else begin
      for (int i = 0; i < TAPS; i++) begin
        r_pixel[i]  <= pixel[i];
        r_weight[i] <= weight[i];
        r_pro[i]    <= prod_t'(r_pixel[i]) * prod_t'(r_weight[i]); // Signed, full width.
      end
    end
  end

  // **********************************************************
  // Rescale back to the data format
  // **********************************************************

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      for (int i = 0; i < TAPS; i++) begin
        r_short[i] <= '0;
      end
    end else begin
      for (int i = 0; i < TAPS; i++) begin
        r_short[i] <= data_t'(r_pro[i] >>> `FRAC); // Keep low bits.
      end
    end
  end

  // **********************************************************
  // Adder tree
  // **********************************************************

  // Sums wrap at the data width.
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lvl0[i] = r_short[2*i] + r_short[2*i+1];
    end
    lvl1[0] = lvl0[0] + lvl0[1];
    lvl1[1] = lvl0[2] + lvl0[3];
    lvl2    = lvl1[0] + lvl1[1];
    lvl3    = lvl2 + r_short[TAPS-1]; // Odd ninth tap.
  end

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      r_sum <= '0;
    end else begin
      r_sum <= lvl3;
    end
  end

  assign fmap = r_sum;

endmodule

`default_nettype wire

//--- hw/line_window.sv
`timescale 1ns/10ps
`default_nettype none

`include "renkon_consts.svh"

module line_window (
  input  logic            clk,
  input  logic            xrst,
  input  logic            shift_en,
  input  conv_pkg::data_t pixel,
  input  conv_pkg::cnt_t  img_width,
  output conv_pkg::data_t win [9]
);
  import conv_pkg::*;

  localparam int AW = $clog2(`MAX_WIDTH);

  data_t         rowbuf [2][`MAX_WIDTH];
  data_t         tap    [2];
  logic [AW-1:0] tap_idx;

  // **********************************************************
  // Row buffers
  // **********************************************************

  // Entry k holds the pixel from k+1 strobes back.
  assign tap_idx = AW'(img_width - cnt_t'(1));
  assign tap[0]  = rowbuf[0][tap_idx]; // One row up.
  assign tap[1]  = rowbuf[1][tap_idx]; // Two rows up.

  always_ff @(posedge clk) begin
    if (shift_en) begin
      rowbuf[0][0] <= pixel;
      rowbuf[1][0] <= tap[0]; // Second buffer chains off the first.
      for (int i = 1; i < `MAX_WIDTH; i++) begin
        rowbuf[0][i] <= rowbuf[0][i-1];
        rowbuf[1][i] <= rowbuf[1][i-1];
      end
    end
  end

  // **********************************************************
  // 3x3 window, row-major, top-left first
  // **********************************************************

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      for (int i = 0; i < 9; i++) begin
        win[i] <= '0;
      end
    end else if (shift_en) begin
      for (int r = 0; r < 3; r++) begin
        win[3*r]   <= win[3*r+1];
        win[3*r+1] <= win[3*r+2];
      end
      win[2] <= tap[1];
      win[5] <= tap[0];
      win[8] <= pixel; // Bottom right is the newest pixel.
    end
  end

endmodule

`default_nettype wire

//--- hw/bias_relu.sv
`timescale 1ns/10ps
`default_nettype none

`include "renkon_consts.svh"

module bias_relu (
  input  logic            clk,
  input  logic            xrst,
  input  conv_pkg::data_t sum,
  input  conv_pkg::data_t bias,
  input  logic            in_valid,
  output conv_pkg::data_t fmap,
  output logic            fmap_valid
);
  import conv_pkg::*;

  localparam data_t MAX_VAL = {1'b0, {(`DWIDTH-1){1'b1}}};
  localparam data_t MIN_VAL = {1'b1, {(`DWIDTH-1){1'b0}}};

  logic signed [`DWIDTH:0] total;
  data_t                   sat;
  data_t                   relu;

  assign total = {sum[`DWIDTH-1], sum} + {bias[`DWIDTH-1], bias}; // One guard bit.

  always_comb begin
    if (!total[`DWIDTH] && total[`DWIDTH-1]) begin
      sat = MAX_VAL; // Positive overflow.
    end else if (total[`DWIDTH] && !total[`DWIDTH-1]) begin
      sat = MIN_VAL;
    end else begin
      sat = data_t'(total);
    end
    relu = sat[`DWIDTH-1] ? data_t'(0) : sat; // Clamp negatives.
  end

  always_ff @(posedge clk) begin
    fmap <= relu;
  end

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      fmap_valid <= 1'b0;
    end else begin
      fmap_valid <= in_valid;
    end
  end

endmodule

`default_nettype wire

//--- hw/conv_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module conv_ctrl (
  input  logic           clk,
  input  logic           xrst,
  input  logic           start,
  input  logic           pixel_valid,
  input  conv_pkg::cnt_t img_width,
  input  conv_pkg::cnt_t img_height,
  output logic           shift_en,
  output logic           tree_valid,
  output logic           done,
  output logic           busy
);
  import conv_pkg::*;

  ctrl_state_t state;
  cnt_t        width_r;
  cnt_t        height_r;
  cnt_t        col;
  cnt_t        row;
  logic        last_px;
  logic        win_ok;
  logic [4:0]  vld_pipe;  // Window register plus tree stages.
  logic [4:0]  last_pipe;

  assign shift_en = pixel_valid && (state == RUN);
  assign win_ok   = shift_en && (row >= cnt_t'(2)) && (col >= cnt_t'(2));
  assign last_px  = shift_en && (row == height_r - cnt_t'(1))
                    && (col == width_r - cnt_t'(1));

  // **********************************************************
  // Frame FSM
  // **********************************************************

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      state    <= IDLE;
      width_r  <= '0;
      height_r <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state    <= RUN;
            width_r  <= img_width;
            height_r <= img_height;
          end
        end
        RUN:     if (last_px) state <= DRAIN;
        DRAIN:   if (done) state <= IDLE; // Last result is out.
        default: state <= IDLE;
      endcase
    end
  end

  // Raster position of the next pixel.
  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      col <= '0;
      row <= '0;
    end else if (state == IDLE && start) begin
      col <= '0;
      row <= '0;
    end else if (shift_en) begin
      if (col == width_r - cnt_t'(1)) begin
        col <= '0;
        row <= row + cnt_t'(1);
      end else begin
        col <= col + cnt_t'(1);
      end
    end
  end

  // **********************************************************
  // Valid and last delay lines
  // **********************************************************

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      vld_pipe  <= '0;
      last_pipe <= '0;
      done      <= 1'b0;
    end else begin
      vld_pipe  <= {vld_pipe[3:0], win_ok};
      last_pipe <= {last_pipe[3:0], last_px};
      done      <= last_pipe[4]; // Lines up with the bias stage.
    end
  end

  assign tree_valid = vld_pipe[4];
  assign busy       = (state != IDLE);

endmodule

`default_nettype wire

//--- hw/conv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module conv_unit (
  input  logic            clk,
  input  logic            xrst,
  input  logic            start,
  input  conv_pkg::cnt_t  img_width,
  input  conv_pkg::cnt_t  img_height,
  input  conv_pkg::data_t pixel,
  input  logic            pixel_valid,
  input  conv_pkg::data_t weight [9],
  input  conv_pkg::data_t bias,
  output conv_pkg::data_t fmap,
  output logic            fmap_valid,
  output logic            done,
  output logic            busy
);
  import conv_pkg::*;

  logic  shift_en;
  logic  tree_valid;
  data_t win [9];
  data_t sum;

  conv_ctrl conv_ctrl_inst (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .pixel_valid (pixel_valid),
    .img_width   (img_width),
    .img_height  (img_height),
    .shift_en    (shift_en),
    .tree_valid  (tree_valid),
    .done        (done),
    .busy        (busy)
  );

  line_window line_window_inst (
    .clk       (clk),
    .xrst      (xrst),
    .shift_en  (shift_en),
    .pixel     (pixel),
    .img_width (img_width),
    .win       (win)
  );

  conv_tree9 conv_tree9_inst (
    .clk    (clk),
    .xrst   (xrst),
    .pixel  (win),
    .weight (weight),
    .fmap   (sum)
  );

  bias_relu bias_relu_inst (
    .clk        (clk),
    .xrst       (xrst),
    .sum        (sum),
    .bias       (bias),
    .in_valid   (tree_valid),
    .fmap       (fmap),
    .fmap_valid (fmap_valid)
  );

endmodule

`default_nettype wire

//--- dv/conv_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "renkon_consts.svh"

module conv_unit_asserts (
  input logic            clk,
  input logic            xrst,
  input conv_pkg::data_t fmap,
  input logic            fmap_valid,
  input logic            done,
  input logic            busy
);
  import conv_pkg::*;

  a_done_valid: assert property (@(posedge clk) disable iff (!xrst) done |-> fmap_valid)
    else $error("done without fmap_valid");

  a_valid_busy: assert property (@(posedge clk) disable iff (!xrst) fmap_valid |-> busy)
    else $error("fmap_valid outside a frame");

  a_reset_quiet: assert property (@(posedge clk) $rose(xrst) |-> !fmap_valid)
    else $error("fmap_valid right after reset");

  a_non_negative: assert property (@(posedge clk) disable iff (!xrst)
    fmap_valid |-> !fmap[`DWIDTH-1])
    else $error("negative fmap after ReLU");

endmodule

bind conv_unit conv_unit_asserts conv_unit_asserts_inst (
  .clk        (clk),
  .xrst       (xrst),
  .fmap       (fmap),
  .fmap_valid (fmap_valid),
  .done       (done),
  .busy       (busy)
);

`default_nettype wire

//--- dv/conv_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "renkon_consts.svh"

module conv_unit_tb;
  import conv_pkg::*;

  logic  clk;
  logic  xrst;
  logic  start;
  cnt_t  img_width;
  cnt_t  img_height;
  data_t pixel;
  logic  pixel_valid;
  data_t weight [9];
  data_t bias;
  data_t fmap;
  logic  fmap_valid;
  logic  done;
  logic  busy;

  logic [15:0] cases [0:255];
  data_t       exp_q [$];
  int          cyc_q [$];
  int          cycles = 0;
  int          limit = 0;
  logic        done_seen = 1'b0;
  integer      seed = 32'h611;

  conv_unit conv_unit_inst (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .img_width   (img_width),
    .img_height  (img_height),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .weight      (weight),
    .bias        (bias),
    .fmap        (fmap),
    .fmap_valid  (fmap_valid),
    .done        (done),
    .busy        (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // **********************************************************
  // Failure reporting and checks
  // **********************************************************

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      report_failure("value check failed");
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      report_failure("timeout, the run did not finish in time");
    end
  end

  // Registered outputs, sampled mid-cycle.
  always @(negedge clk) begin
    if (done_seen) begin
      check_value(32'(busy), 32'd0, "busy one cycle after done");
    end
    done_seen = xrst && done;
    if (xrst && fmap_valid) begin
      if (exp_q.size() == 0) begin
        report_failure("extra output with no expected value left");
      end else begin
        check_value(32'(fmap), 32'(exp_q.pop_front()), "fmap value");
        check_value(cycles - cyc_q.pop_front(), 6, "output latency");
        if (done !== (exp_q.size() == 0)) begin
          report_failure("done is missing or early on an output");
        end
      end
    end else if (xrst && done) begin
      report_failure("done came without an output");
    end
  end

  // **********************************************************
  // Stimulus from the case file
  // **********************************************************

  initial begin
    int idx;
    int w;
    int h;
    int total_px;
    int gap_mode;
    int gap;

    start       = 1'b0;
    img_width   = '0;
    img_height  = '0;
    pixel       = '0;
    pixel_valid = 1'b0;
    bias        = '0;
    for (int i = 0; i < 9; i++) begin
      weight[i] = '0;
    end
    xrst = 1'b0;

    $readmemh("dv/conv_unit_cases.txt", cases);
    idx      = 0;
    total_px = 0;
    while (cases[idx] != 16'h0000) begin
      w        = int'(cases[idx]);
      h        = int'(cases[idx+1]);
      total_px += w * h;
      idx      += 13 + w * h + (w - 2) * (h - 2);
    end
    limit = total_px * 4 + 100;
    if (total_px == 0) begin
      report_failure("case file holds no frames");
    end

    repeat (8) @(posedge clk);
    #10 xrst = 1'b1;

    idx = 0;
    while (cases[idx] != 16'h0000) begin
      w        = int'(cases[idx]);
      h        = int'(cases[idx+1]);
      gap_mode = int'(cases[idx+3]);

      // Stray strobes while idle.
      for (int i = 0; i < 3; i++) begin
        @(posedge clk);
        #10;
        pixel       = 16'h7fff;
        pixel_valid = 1'b1;
      end
      @(posedge clk);
      #10 pixel_valid = 1'b0;
      repeat (6) @(posedge clk); // Room for a wrongly accepted window.
      #10;

      img_width  = cnt_t'(w);
      img_height = cnt_t'(h);
      bias       = data_t'(cases[idx+2]);
      for (int i = 0; i < 9; i++) begin
        weight[i] = data_t'(cases[idx+4+i]);
      end
      for (int i = 0; i < (w - 2) * (h - 2); i++) begin
        exp_q.push_back(data_t'(cases[idx+13+w*h+i]));
      end
      start = 1'b1;
      @(posedge clk);
      #10 start = 1'b0;
      check_value(32'(busy), 32'd1, "busy after start");

      for (int r = 0; r < h; r++) begin
        for (int c = 0; c < w; c++) begin
          gap = (gap_mode != 0) ? ({$random(seed)} % 3) : 0;
          repeat (gap) begin
            @(posedge clk);
            #10;
          end
          pixel       = data_t'(cases[idx+13+r*w+c]);
          pixel_valid = 1'b1;
          if (r >= 2 && c >= 2) begin
            cyc_q.push_back(cycles); // Window-completing strobe.
          end
          @(posedge clk);
          #10 pixel_valid = 1'b0;
        end
      end

      while (busy) begin
        @(posedge clk);
        #10;
      end
      if (exp_q.size() != 0) begin
        report_failure("frame ended with outputs still missing");
      end
      idx += 13 + w * h + (w - 2) * (h - 2);
    end

    repeat (10) @(posedge clk); // Catch any late output.
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/conv_unit_cases.txt
// Per frame: width height bias gap_mode, then weights w0..w8 (row-major),
// then width*height pixels in raster order, then the expected outputs. A width of 0 ends the list.
// Frame 1, 5x4, identity weights, zero bias.
0005 0004 0000 0000
0000 0000 0000 0000 0100 0000 0000 0000 0000
0010 0020 0030 0040 0050
0060 0170 FF80 0090 00A0
00B0 0123 0045 FE00 00F0
0001 0002 0003 0004 0005
0170 0000 0090
0123 0045 0000
// Frame 2, 4x3, mixed-sign fractional weights, random gaps, wrapping sum.
0004 0003 7800 0001
0080 FF80 0040 0100 FFC0 0200 0000 0180 FF00
0003 0005 0101 0007
0100 7000 0011 1000
0004 0009 FFFD 0010
5D70 0768
// Frame 3, 3x4, saturating bias and a large negative sum.
0003 0004 7000 0000
0000 0000 0000 0000 0100 0000 0000 0000 0000
0001 0002 0003
0004 2000 0006
0007 8000 0009
000A 000B 000C
7FFF 0000
// End of list.
0000

//--- conv_unit.f
+incdir+hw
hw/conv_pkg.sv
hw/conv_tree9.sv
hw/line_window.sv
hw/bias_relu.sv
hw/conv_ctrl.sv
hw/conv_unit.sv
dv/conv_unit_asserts.sv
dv/conv_unit_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f conv_unit.f --top-module conv_unit_tb -Mdir obj_dir

run: compile
	./obj_dir/Vconv_unit_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
